//--- bench/ch_est_ctrl_assert.sv
`timescale 1ns/1ps
`include "ch_est_consts.svh"

module ch_est_ctrl_assert (
    input logic                  clk,
    input logic                  rst,
    input logic                  est_ack_nrs,
    input logic                  est_ack_demap,
    input logic                  demap_read,
    input ch_est_pkg::est_mem_t  mem,
    input ch_est_pkg::eqlz_sel_t sel
);

    // length of the current valid run
    logic [3:0] run_len;
    // sticky flags, read by the testbench top
    logic       bad_excl = 1'b0;
    logic       bad_read = 1'b0;
    logic       bad_mult = 1'b0;
    logic       bad_win  = 1'b0;
    logic       fail_seen;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            run_len <= 4'd0;
        end else if (sel.valid) begin
            run_len <= run_len + 4'd1;
        end else begin
            run_len <= 4'd0;
        end
    end

    assign fail_seen = bad_excl | bad_read | bad_mult | bad_win;

    // ======================================================================
    // handshake and timing properties
    // ======================================================================

    acks_exclusive: assert property (@(posedge clk) disable iff (!rst)
        !(est_ack_nrs && est_ack_demap))
    else begin
        bad_excl = 1'b1;
        $error("est_ack_nrs and est_ack_demap high together");
    end

    // any ack means the demapper is being read
    ack_reads: assert property (@(posedge clk) disable iff (!rst)
        (est_ack_nrs || est_ack_demap) |-> demap_read)
    else begin
        bad_read = 1'b1;
        $error("acknowledge without demap_read");
    end

    mult_en_delay: assert property (@(posedge clk) disable iff (!rst)
        mem.mult_mem_en == $past(est_ack_nrs))
    else begin
        bad_mult = 1'b1;
        $error("mult_mem_en does not trail est_ack_nrs by one cycle");
    end

    // too long, then too short
    window_max: assert property (@(posedge clk) disable iff (!rst)
        sel.valid |-> run_len < 4'(`CE_SEQ_STEPS))
    else begin
        bad_win = 1'b1;
        $error("valid_eqlz window longer than expected");
    end

    window_len: assert property (@(posedge clk) disable iff (!rst)
        $fell(sel.valid) |-> run_len == 4'(`CE_SEQ_STEPS))
    else begin
        bad_win = 1'b1;
        $error("valid_eqlz window shorter than expected");
    end

endmodule

//--- bench/tb_ch_est_ctrl.sv
`timescale 1ns/1ps
`include "ch_est_consts.svh"

module tb_ch_est_ctrl;

    localparam int WAIT_LIMIT = 64;

    logic                    clk;
    logic                    rst;
    logic                    demap_ready;
    logic                    nrs_gen_ready;
    logic [2:0]              v_shift;
    logic                    est_ack_nrs;
    logic                    est_ack_demap;
    logic                    demap_read;
    ch_est_pkg::est_mem_t    mem;
    ch_est_pkg::demap_addr_t addr;
    ch_est_pkg::eqlz_sel_t   sel;

    // reference model state
    bit first_slot;
    int col_idx;
    int nrs_idx;
    int rom_addr;
    int cls;
    // bookkeeping
    int n_checks;
    int n_err;
    int n_tests;
    bit timed_out;

    tb_clk_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    ch_est_ctrl_top u_dut (
        .clk           (clk),
        .rst           (rst),
        .demap_ready   (demap_ready),
        .nrs_gen_ready (nrs_gen_ready),
        .v_shift       (v_shift),
        .est_ack_nrs   (est_ack_nrs),
        .est_ack_demap (est_ack_demap),
        .demap_read    (demap_read),
        .mem           (mem),
        .addr          (addr),
        .sel           (sel)
    );

    bind ch_est_ctrl_top ch_est_ctrl_assert u_chk (
        .clk           (clk),
        .rst           (rst),
        .est_ack_nrs   (est_ack_nrs),
        .est_ack_demap (est_ack_demap),
        .demap_read    (demap_read),
        .mem           (mem),
        .sel           (sel)
    );

    // ======================================================================
    // model helpers
    // ======================================================================

    // 0/3, 1/4, rest
    function automatic int class_of(input int vs);
        if (vs == 0 || vs == 3) return 0;
        if (vs == 1 || vs == 4) return 1;
        return 2;
    endfunction

    // addr struct as col, pilot index, rom address
    function automatic int addr_exp();
        int col;
        col = (col_idx == 0) ? int'(`CE_COL_0) : (col_idx == 1) ? int'(`CE_COL_1) :
              (col_idx == 2) ? int'(`CE_COL_2) : int'(`CE_COL_3);
        return (col << (2 + `CE_NRS_ADDR_W)) | (nrs_idx << `CE_NRS_ADDR_W) | rom_addr;
    endfunction

    // select pair k of the h1 or h2 table
    function automatic int sel_pair(input bit h2, input int c, input int k);
        logic [`CE_SEQ_LEN-1:0] tab;
        if (c == 1) tab = h2 ? `CE_SEL_H2_S1 : `CE_SEL_H1_S1;
        else if (c == 2) tab = h2 ? `CE_SEL_H2_S2 : `CE_SEL_H1_S2;
        else tab = h2 ? `CE_SEL_H2_S0 : `CE_SEL_H1_S0;
        return int'((tab >> (2 * k)) & 12'h3);
    endfunction

    task automatic check_val(input string name, input int got, input int exp);
        n_checks++;
        assert (got == exp) else begin
            n_err++;
            $display("FAILED %s at %0t: got 0x%0h, expected 0x%0h", name, $time, got, exp);
        end
    endtask

    task automatic check_window(input int k);
        check_val("valid_eqlz", int'(sel.valid), 1);
        check_val("s_h1", int'(sel.s_h1), sel_pair(1'b0, cls, k));
        check_val("s_h2", int'(sel.s_h2), sel_pair(1'b1, cls, k));
        check_val("s_est", int'(sel.s_est), int'(cls == 1));
    endtask

    task automatic set_shift(input int vs);
        @(posedge clk);
        v_shift <= 3'(vs);
    endtask

    // one pilot pass; readies rise after random gaps, vs_late >= 0 moves v_shift in the pass
    task automatic do_pass(input int max_gap, input int vs_late);
        int gap_a;
        int gap_b;
        int n;
        int k;
        bit started;
        bit store;
        if (timed_out) return;
        gap_a = int'($urandom_range(max_gap));
        gap_b = int'($urandom_range(max_gap));
        started = 1'b0;
        for (n = 0; n < WAIT_LIMIT && !started; n++) begin
            @(posedge clk);
            if (n == gap_a) demap_ready <= 1'b1;
            if (n == gap_b) nrs_gen_ready <= 1'b1;
            @(negedge clk);
            started = demap_read;
            // idle: no ack yet
            if (!started) begin
                check_val("est_ack_nrs", int'(est_ack_nrs), 0);
                check_val("est_ack_demap", int'(est_ack_demap), 0);
            end
        end
        if (!started) begin
            $display("timeout: no pilot pass started within %0d cycles", WAIT_LIMIT);
            timed_out = 1'b1;
            return;
        end
        store = first_slot;
        for (k = 0; k < `CE_PASS_LEN; k++) begin
            if (store && k == 0) cls = class_of(int'(v_shift));
            check_val("est_ack_nrs", int'(est_ack_nrs), int'(store));
            check_val("est_ack_demap", int'(est_ack_demap), int'(!store));
            check_val("demap_read", int'(demap_read), 1);
            check_val("mem", int'(mem), (k << 2) | (int'(store && k > 0) << 1) |
                      int'(!store && k > 0));
            check_val("addr", int'(addr), addr_exp());
            if (!store && k == 3) check_window(0);
            else check_val("valid_eqlz", int'(sel.valid), 0);
            nrs_idx = (nrs_idx + 1) % 4;
            rom_addr = (rom_addr + `CE_NRS_ADDR_STEP) % (1 << `CE_NRS_ADDR_W);
            if (k % 2 == 1) col_idx = (col_idx + 1) % 4;
            @(posedge clk);
            if (k == 0) begin
                demap_ready <= 1'b0;
                nrs_gen_ready <= 1'b0;
                if (vs_late >= 0) v_shift <= 3'(vs_late);
            end
            @(negedge clk);
        end
        first_slot = !first_slot;
        check_val("mem", int'(mem), (int'(store) << 1) | int'(!store));
        // rest of the select window after an add pass
        if (!store) begin
            for (k = 1; k <= `CE_SEQ_STEPS; k++) begin
                check_val("demap_read", int'(demap_read), 0);
                if (k < `CE_SEQ_STEPS) check_window(k);
                else check_val("valid_eqlz", int'(sel.valid), 0);
                @(negedge clk);
            end
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        n_tests++;
        $display("test %0d %s: %s, %0d errors", n_tests, name,
                 (n_err == err_before) ? "ok" : "mismatch", n_err - err_before);
    endtask

    // ======================================================================
    // test sequence
    // ======================================================================

    initial begin
        int e0;
        int n;
        int i;
        int vs;
        void'($urandom(9319));
        demap_ready = 1'b0;
        nrs_gen_ready = 1'b0;
        v_shift = 3'd0;
        first_slot = 1'b1;
        for (n = 0; n < WAIT_LIMIT && rst !== 1'b1; n++) @(negedge clk);
        if (rst !== 1'b1) begin
            $display("timeout: reset never released");
            timed_out = 1'b1;
        end
        if (!timed_out) begin
            e0 = n_err;
            @(negedge clk);
            check_val("demap_read", int'(demap_read), 0);
            check_val("est_ack_nrs", int'(est_ack_nrs), 0);
            check_val("est_ack_demap", int'(est_ack_demap), 0);
            check_val("mem", int'(mem), 0);
            check_val("addr", int'(addr), addr_exp());
            check_val("valid_eqlz", int'(sel.valid), 0);
            check_val("s_est", int'(sel.s_est), 0);
            end_test("reset", e0);
        end
        if (!timed_out) begin
            e0 = n_err;
            do_pass(0, -1);
            do_pass(0, -1);
            end_test("pass alternation", e0);
        end
        // columns and rom address wrap after two passes
        if (!timed_out) begin
            e0 = n_err;
            for (i = 0; i < 4; i++) do_pass(0, -1);
            end_test("addressing", e0);
        end
        if (!timed_out) begin
            e0 = n_err;
            for (i = 0; i < 3; i++) begin
                set_shift((i == 0) ? 0 : (i == 1) ? 4 : 5);
                if (!first_slot) do_pass(0, -1);
                do_pass(0, -1);
                do_pass(0, -1);
            end
            end_test("select sequencing", e0);
        end
        // class must hold across late v_shift moves
        if (!timed_out) begin
            e0 = n_err;
            for (i = 0; i < 4; i++) begin
                vs = int'($urandom_range(7));
                set_shift(vs);
                // late values always fall in one of the other two classes
                do_pass(5, (class_of(vs) + 1) % 3);
                set_shift((class_of(vs) + 2) % 3);
                do_pass(5, 1);
            end
            end_test("random ready timing", e0);
        end
        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_err);
        if (n_err == 0 && !timed_out && !u_dut.u_chk.fail_seen) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- bench/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held low for three rising edges
    initial begin
        rst = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

//--- filelist.f
+incdir+hw
hw/ch_est_pkg.sv
hw/shift_cfg.sv
hw/pilot_pass_fsm.sv
hw/demap_addr_gen.sv
hw/eqlz_sel_seq.sv
hw/ch_est_ctrl_top.sv
bench/tb_clk_gen.sv
bench/ch_est_ctrl_assert.sv
bench/tb_ch_est_ctrl.sv

//--- hw/ch_est_consts.svh
`ifndef CH_EST_CONSTS_SVH
`define CH_EST_CONSTS_SVH

// ======================================================================
// pilot pass timing
// ======================================================================

// cycles per pilot pass
`define CE_PASS_LEN       4

// pilot rom addressing
`define CE_NRS_ADDR_W     4
`define CE_NRS_ADDR_STEP  2

// pilot-carrying columns of a subframe
`define CE_COL_0          4'd5
`define CE_COL_1          4'd6
`define CE_COL_2          4'd12
`define CE_COL_3          4'd13

// ======================================================================
// equalizer select tables
// ======================================================================

`define CE_SEQ_LEN        12
`define CE_SEQ_STEPS      6

// pair 0 sits in the low bits, shifted out first
`define CE_SEL_H1_S0      12'b01_11_10_11_01_00
`define CE_SEL_H2_S0      12'b10_11_00_00_01_00
`define CE_SEL_H1_S1      12'b10_11_01_00_01_01
`define CE_SEL_H2_S1      12'b00_10_11_10_10_01
`define CE_SEL_H1_S2      12'b01_10_11_11_00_11
`define CE_SEL_H2_S2      12'b11_10_00_01_00_00

`endif

//--- hw/ch_est_ctrl_top.sv
`timescale 1ns/1ps

module ch_est_ctrl_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    demap_ready,
    input  logic                    nrs_gen_ready,
    input  logic [2:0]              v_shift,
    output logic                    est_ack_nrs,
    output logic                    est_ack_demap,
    output logic                    demap_read,
    output ch_est_pkg::est_mem_t    mem,
    output ch_est_pkg::demap_addr_t addr,
    output ch_est_pkg::eqlz_sel_t   sel
);

    ch_est_pkg::pass_info_t   pass;
    ch_est_pkg::shift_class_e shift_class;
    logic                     store_start;
    logic                     s_est;

    // ==================================================================
    // pass sequencing
    // ==================================================================

    pilot_pass_fsm u_pass (
        .clk           (clk),
        .rst           (rst),
        .demap_ready   (demap_ready),
        .nrs_gen_ready (nrs_gen_ready),
        .pass          (pass),
        .store_start   (store_start),
        .est_ack_nrs   (est_ack_nrs),
        .est_ack_demap (est_ack_demap),
        .demap_read    (demap_read),
        .mem           (mem)
    );

    // class held per slot pair
    shift_cfg u_shift_cfg (
        .clk         (clk),
        .rst         (rst),
        .v_shift     (v_shift),
        .store_start (store_start),
        .shift_class (shift_class),
        .s_est       (s_est)
    );

    // ==================================================================
    // addressing and equalizer selects
    // ==================================================================

    demap_addr_gen u_addr (
        .clk  (clk),
        .rst  (rst),
        .pass (pass),
        .addr (addr)
    );

    eqlz_sel_seq u_sel (
        .clk         (clk),
        .rst         (rst),
        .pass        (pass),
        .shift_class (shift_class),
        .s_est       (s_est),
        .sel         (sel)
    );

endmodule

//--- hw/ch_est_pkg.sv
`include "ch_est_consts.svh"

package ch_est_pkg;

    // ==================================================================
    // state and class encodings
    // ==================================================================

    // pilot pass state, store and add differ in bit 1 only
    typedef enum logic [1:0] {
        PASS_IDLE  = 2'b00,
        PASS_STORE = 2'b01,
        PASS_ADD   = 2'b11
    } pass_state_e;

    // cyclic pilot shift class, picks the select tables
    typedef enum logic [1:0] {
        SHIFT_0 = 2'd0,
        SHIFT_1 = 2'd1,
        SHIFT_2 = 2'd2
    } shift_class_e;

    // ==================================================================
    // grouped signals
    // ==================================================================

    // pass activity from the pass fsm
    typedef struct packed {
        logic       active;
        logic       store;
        logic [1:0] cnt;
        // third averaged estimate done
        logic       est_ready;
    } pass_info_t;

    // estimate memory controls
    typedef struct packed {
        logic [1:0] addr_mem;
        logic       mult_mem_en;
        logic       avg_mem_en;
    } est_mem_t;

    // demapper and pilot rom addressing
    typedef struct packed {
        logic [3:0]                col;
        logic [1:0]                nrs_index_addr;
        logic [`CE_NRS_ADDR_W-1:0] rd_addr_nrs;
    } demap_addr_t;

    // output mux selects toward the equalizer
    typedef struct packed {
        logic       valid;
        logic [1:0] s_h1;
        logic [1:0] s_h2;
        logic       s_est;
    } eqlz_sel_t;

endpackage

//--- hw/demap_addr_gen.sv
`timescale 1ns/1ps
`include "ch_est_consts.svh"

module demap_addr_gen (
    input  logic                    clk,
    input  logic                    rst,
    input  ch_est_pkg::pass_info_t  pass,
    output ch_est_pkg::demap_addr_t addr
);

    logic [1:0]                col_idx_q;
    logic [1:0]                nrs_idx_q;
    logic [`CE_NRS_ADDR_W-1:0] rom_addr_q;
    logic [3:0]                col;

    // ==================================================================
    // free running counters, advance only inside a pass
    // ==================================================================

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            col_idx_q  <= 2'd0;
            nrs_idx_q  <= 2'd0;
            rom_addr_q <= '0;
        end else if (pass.active) begin
            nrs_idx_q  <= nrs_idx_q + 2'd1;
            rom_addr_q <= rom_addr_q + `CE_NRS_ADDR_W'(`CE_NRS_ADDR_STEP);
            // two cycles per column
            if (pass.cnt[0]) begin
                col_idx_q <= col_idx_q + 2'd1;
            end
        end
    end

    // pilot columns of the subframe
    always_comb begin
        case (col_idx_q)
            2'd0:    col = `CE_COL_0;
            2'd1:    col = `CE_COL_1;
            2'd2:    col = `CE_COL_2;
            default: col = `CE_COL_3;
        endcase
    end

    assign addr.col            = col;
    assign addr.nrs_index_addr = nrs_idx_q;
    assign addr.rd_addr_nrs    = rom_addr_q;

endmodule

//--- hw/eqlz_sel_seq.sv
`timescale 1ns/1ps
`include "ch_est_consts.svh"

module eqlz_sel_seq (
    input  logic                     clk,
    input  logic                     rst,
    input  ch_est_pkg::pass_info_t   pass,
    input  ch_est_pkg::shift_class_e shift_class,
    input  logic                     s_est,
    output ch_est_pkg::eqlz_sel_t    sel
);

    logic [`CE_SEQ_LEN-1:0] h1_q;
    logic [`CE_SEQ_LEN-1:0] h2_q;
    logic [2:0]             win_cnt_q;
    logic                   valid_q;
    logic                   win_last;

    // ==================================================================
    // valid window
    // ==================================================================

    assign win_last = (win_cnt_q == 3'(`CE_SEQ_STEPS - 1));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q   <= 1'b0;
            win_cnt_q <= 3'd0;
        end else if (pass.est_ready) begin
            valid_q   <= 1'b1;
            win_cnt_q <= 3'd0;
        end else if (valid_q) begin
            win_cnt_q <= win_cnt_q + 3'd1;
            if (win_last) begin
                valid_q <= 1'b0;
            end
        end
    end

    // ==================================================================
    // select tables
    // ==================================================================

    // loaded with the window start, one pair dropped per valid cycle
    always_ff @(posedge clk) begin
        if (pass.est_ready) begin
            case (shift_class)
                ch_est_pkg::SHIFT_1: begin
                    h1_q <= `CE_SEL_H1_S1;
                    h2_q <= `CE_SEL_H2_S1;
                end
                ch_est_pkg::SHIFT_2: begin
                    h1_q <= `CE_SEL_H1_S2;
                    h2_q <= `CE_SEL_H2_S2;
                end
                default: begin
                    h1_q <= `CE_SEL_H1_S0;
                    h2_q <= `CE_SEL_H2_S0;
                end
            endcase
        end else if (valid_q) begin
            h1_q <= h1_q >> 2;
            h2_q <= h2_q >> 2;
        end
    end

    assign sel.valid = valid_q;
    assign sel.s_h1  = h1_q[1:0];
    assign sel.s_h2  = h2_q[1:0];
    assign sel.s_est = s_est;

endmodule

//--- hw/pilot_pass_fsm.sv
`timescale 1ns/1ps
`include "ch_est_consts.svh"

module pilot_pass_fsm (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   demap_ready,
    input  logic                   nrs_gen_ready,
    output ch_est_pkg::pass_info_t pass,
    output logic                   store_start,
    output logic                   est_ack_nrs,
    output logic                   est_ack_demap,
    output logic                   demap_read,
    output ch_est_pkg::est_mem_t   mem
);

    ch_est_pkg::pass_state_e state_q;
    ch_est_pkg::pass_state_e state_next;
    logic [1:0] cnt_q;
    logic       first_slot_q;
    logic       active;
    logic       pass_done;
    logic       mult_en_q;
    logic       avg_en_q;

    // ==================================================================
    // pass state
    // ==================================================================

    assign active    = (state_q != ch_est_pkg::PASS_IDLE);
    // last cycle of a pass
    assign pass_done = active && (cnt_q == 2'(`CE_PASS_LEN - 1));

    always_comb begin
        state_next = state_q;
        case (state_q)
            ch_est_pkg::PASS_IDLE: begin
                // both sources holding a pilot cell
                if (demap_ready && nrs_gen_ready) begin
                    if (first_slot_q) begin
                        state_next = ch_est_pkg::PASS_STORE;
                    end else begin
                        state_next = ch_est_pkg::PASS_ADD;
                    end
                end
            end
            ch_est_pkg::PASS_STORE,
            ch_est_pkg::PASS_ADD: begin
                if (pass_done) begin
                    state_next = ch_est_pkg::PASS_IDLE;
                end
            end
            default: state_next = ch_est_pkg::PASS_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q      <= ch_est_pkg::PASS_IDLE;
            cnt_q        <= 2'd0;
            first_slot_q <= 1'b1;
        end else begin
            state_q <= state_next;
            // wraps back to 0 on the exit edge
            if (active) begin
                cnt_q <= cnt_q + 2'd1;
            end
            // slot flag flips after every pass
            if (pass_done) begin
                first_slot_q <= ~first_slot_q;
            end
        end
    end

    // ==================================================================
    // decoded outputs
    // ==================================================================

    assign est_ack_nrs   = (state_q == ch_est_pkg::PASS_STORE);
    assign est_ack_demap = (state_q == ch_est_pkg::PASS_ADD);
    assign demap_read    = active;
    // first cycle of a store pass, class latch
    assign store_start   = est_ack_nrs && (cnt_q == 2'd0);

    assign pass.active    = active;
    assign pass.store     = est_ack_nrs;
    assign pass.cnt       = cnt_q;
    assign pass.est_ready = est_ack_demap && (cnt_q == 2'd2);

    // write enables trail the product by one cycle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mult_en_q <= 1'b0;
            avg_en_q  <= 1'b0;
        end else begin
            mult_en_q <= est_ack_nrs;
            avg_en_q  <= est_ack_demap;
        end
    end

    assign mem.addr_mem    = cnt_q;
    assign mem.mult_mem_en = mult_en_q;
    assign mem.avg_mem_en  = avg_en_q;

endmodule

//--- hw/shift_cfg.sv
`timescale 1ns/1ps

module shift_cfg (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [2:0]               v_shift,
    input  logic                     store_start,
    output ch_est_pkg::shift_class_e shift_class,
    output logic                     s_est
);

    ch_est_pkg::shift_class_e class_next;
    ch_est_pkg::shift_class_e class_q;

    // v_shift mod 3 picks the pilot layout
    always_comb begin
        case (v_shift)
            3'd0, 3'd3: class_next = ch_est_pkg::SHIFT_0;
            3'd1, 3'd4: class_next = ch_est_pkg::SHIFT_1;
            default:    class_next = ch_est_pkg::SHIFT_2;
        endcase
    end

    // held over a store/add slot pair
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            class_q <= ch_est_pkg::SHIFT_0;
        end else if (store_start) begin
            class_q <= class_next;
        end
    end

    assign shift_class = class_q;

    // shift 1 swaps estimate pairs between the two output muxes
    assign s_est = (class_q == ch_est_pkg::SHIFT_1);

endmodule

//--- run.sh
#!/bin/sh
# build with Verilator and run the channel estimator control testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_ch_est_ctrl -o sim_tb \
    || { echo "build failed"; exit 1; }

out=$(./obj_dir/sim_tb +verilator+error+limit+1000)
echo "$out"

echo "$out" | grep -qx "TEST PASS" && echo "run ok" || { echo "run failed"; exit 1; }
